/* design/pmu_bus_pkg.sv */
package pmu_bus_pkg;

	typedef logic [7:0] bus_byte_t;
	typedef logic [7:0] eid_t;
	typedef logic [1:0] rail_idx_t;
	typedef logic [4:0] dac_code_t;

	typedef enum logic {PARAM_ENABLE, PARAM_VOLTAGE} param_kind_t;

	typedef struct packed {
		eid_t eid;
		param_kind_t kind;
		rail_idx_t rail;
		bus_byte_t value;
	} set_cmd_t;

	typedef struct packed {
		eid_t eid;
		param_kind_t kind;
		rail_idx_t rail;
	} query_cmd_t;

	typedef struct packed {
		eid_t eid;
		logic query;
		logic ok;
		bus_byte_t data;
	} reply_t;

	localparam bus_byte_t REPLY_ADDR = 8'h20;
	localparam bus_byte_t ACK_CODE = 8'h01;
	localparam bus_byte_t NAK_CODE = 8'h00;
	localparam bus_byte_t PARAM_VOLTAGE_CHAR = 8'h76;

endpackage

/* design/pmu_i2c_pkg.sv */
package pmu_i2c_pkg;

	typedef struct packed {
		logic rd;
		logic [7:0] subaddr;
		logic [7:0] wdata;
	} i2c_req_t;

	typedef struct packed {
		logic failed;
		logic [7:0] rdata;
	} i2c_rsp_t;

	localparam logic [7:0] DEV_ADDR_WR = 8'h68;
	localparam logic [7:0] DEV_ADDR_RD = 8'h69;
	localparam logic [7:0] REG_ENABLE = 8'h10;
	localparam logic [7:0] REG_SLEW = 8'h20;
	localparam logic [7:0] SLEW_VALUE = 8'h55;

	// Indexed by rail number, rail 0 is the rightmost entry
	localparam logic [3:0][7:0] VOLT_REG = {8'h23, 8'h29, 8'h26, 8'h32};
	localparam logic [3:0][2:0] EN_BIT = {3'd0, 3'd2, 3'd1, 3'd4};

endpackage

/* design/frame_receiver.sv */
`timescale 1ns/100ps

module frame_receiver #(
	parameter pmu_bus_pkg::bus_byte_t SET_ADDR = 8'h70,
	parameter pmu_bus_pkg::bus_byte_t QUERY_ADDR = 8'h50
) (
	input logic clk,
	input logic reset,
	input logic rx_frame,
	input logic rx_valid,
	input pmu_bus_pkg::bus_byte_t rx_byte,
	output pmu_bus_pkg::set_cmd_t set_cmd,
	output logic set_strobe,
	output pmu_bus_pkg::query_cmd_t query_cmd,
	output logic query_strobe
);

	typedef enum logic [1:0] {ST_IDLE, ST_HEADER, ST_BODY, ST_SKIP} state_t;

	state_t state;
	logic [2:0] cnt;
	logic is_set;
	pmu_bus_pkg::eid_t eid;
	pmu_bus_pkg::param_kind_t kind;
	pmu_bus_pkg::rail_idx_t rail;
	pmu_bus_pkg::bus_byte_t value;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			cnt <= '0;
			is_set <= 1'b0;
			set_strobe <= 1'b0;
			query_strobe <= 1'b0;
		end else begin
			set_strobe <= 1'b0;
			query_strobe <= 1'b0;
			// A frame that ends before its last needed byte is dropped here
			if (!rx_frame) begin
				state <= ST_IDLE;
			end else if (rx_valid) begin
				case (state)
					ST_IDLE: begin
						cnt <= 3'd1;
						is_set <= (rx_byte == SET_ADDR);
						if (rx_byte == SET_ADDR || rx_byte == QUERY_ADDR)
							state <= ST_HEADER;
						else
							state <= ST_SKIP;
					end
					ST_HEADER: begin
						cnt <= cnt + 1'b1;
						state <= ST_BODY;
					end
					ST_BODY: begin
						cnt <= cnt + 1'b1;
						if (cnt == 3'd3 && !is_set) begin
							query_strobe <= 1'b1;
							state <= ST_SKIP;
						end
						if (cnt == 3'd4) begin
							set_strobe <= 1'b1;
							state <= ST_SKIP;
						end
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rx_frame && rx_valid && (state == ST_HEADER || state == ST_BODY)) begin
			case (cnt)
				3'd1: eid <= rx_byte;
				3'd2: kind <= (rx_byte == pmu_bus_pkg::PARAM_VOLTAGE_CHAR) ?
					pmu_bus_pkg::PARAM_VOLTAGE : pmu_bus_pkg::PARAM_ENABLE;
				3'd3: rail <= rx_byte[1:0];
				3'd4: value <= rx_byte;
				default: ;
			endcase
		end
	end

	always_comb begin
		set_cmd.eid = eid;
		set_cmd.kind = kind;
		set_cmd.rail = rail;
		set_cmd.value = value;
		query_cmd.eid = eid;
		query_cmd.kind = kind;
		query_cmd.rail = rail;
	end

endmodule

/* design/rail_set_engine.sv */
`timescale 1ns/100ps

module rail_set_engine (
	input logic clk,
	input logic reset,
	input pmu_bus_pkg::set_cmd_t set_cmd,
	input logic set_strobe,
	input logic grant,
	input logic i2c_done,
	input pmu_i2c_pkg::i2c_rsp_t i2c_rsp,
	output pmu_i2c_pkg::i2c_req_t i2c_req,
	output logic i2c_req_valid,
	output pmu_bus_pkg::reply_t reply,
	output logic reply_strobe
);

	typedef enum logic [1:0] {S_IDLE, S_VALUE, S_SLEW} state_t;

	state_t state;
	pmu_bus_pkg::set_cmd_t cmd;
	pmu_bus_pkg::dac_code_t code;
	logic [3:0] en_shadow;
	logic [7:0] en_byte;
	logic own_done;
	logic failed;
	logic ok_q;

	assign own_done = i2c_done && grant;
	assign i2c_req_valid = (state != S_IDLE);
	assign code = cmd.value[4:0];

	// The power IC keeps each rail's enable at its own bit of REG_ENABLE
	always_comb begin
		en_byte = '0;
		for (int i = 0; i < 4; i++) begin
			en_byte[pmu_i2c_pkg::EN_BIT[i]] = en_shadow[i];
		end
	end

	always_comb begin
		i2c_req.rd = 1'b0;
		if (state == S_SLEW) begin
			i2c_req.subaddr = pmu_i2c_pkg::REG_SLEW;
			i2c_req.wdata = pmu_i2c_pkg::SLEW_VALUE;
		end else if (cmd.kind == pmu_bus_pkg::PARAM_VOLTAGE) begin
			i2c_req.subaddr = pmu_i2c_pkg::VOLT_REG[cmd.rail];
			i2c_req.wdata = {3'b000, code};
		end else begin
			i2c_req.subaddr = pmu_i2c_pkg::REG_ENABLE;
			i2c_req.wdata = en_byte;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			en_shadow <= '0;
			reply_strobe <= 1'b0;
		end else begin
			reply_strobe <= 1'b0;
			case (state)
				S_IDLE: begin
					if (set_strobe) begin
						state <= S_VALUE;
						if (set_cmd.kind == pmu_bus_pkg::PARAM_ENABLE)
							en_shadow[set_cmd.rail] <= set_cmd.value[0];
					end
				end
				S_VALUE: if (own_done) state <= S_SLEW;
				default: begin
					if (own_done) begin
						state <= S_IDLE;
						reply_strobe <= 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && set_strobe) begin
			cmd <= set_cmd;
			failed <= 1'b0;
		end else if (own_done) begin
			failed <= failed || i2c_rsp.failed;
		end
		if (state == S_SLEW && own_done)
			ok_q <= !(failed || i2c_rsp.failed);
	end

	always_comb begin
		reply.eid = cmd.eid;
		reply.query = 1'b0;
		reply.ok = ok_q;
		reply.data = '0;
	end

	req_held: assert property (@(posedge clk) disable iff (reset)
		i2c_req_valid && !i2c_done |=> i2c_req_valid)
		else $error("set engine dropped its I2C request before done");

endmodule

/* design/rail_query_engine.sv */
`timescale 1ns/100ps

module rail_query_engine (
	input logic clk,
	input logic reset,
	input pmu_bus_pkg::query_cmd_t query_cmd,
	input logic query_strobe,
	input logic grant,
	input logic i2c_done,
	input pmu_i2c_pkg::i2c_rsp_t i2c_rsp,
	output pmu_i2c_pkg::i2c_req_t i2c_req,
	output logic i2c_req_valid,
	output pmu_bus_pkg::reply_t reply,
	output logic reply_strobe
);

	typedef enum logic {Q_IDLE, Q_READ} state_t;

	state_t state;
	pmu_bus_pkg::query_cmd_t cmd;
	pmu_bus_pkg::bus_byte_t data_q;
	logic own_done;
	logic en_bit;
	logic ok_q;

	assign own_done = i2c_done && grant;
	assign i2c_req_valid = (state == Q_READ);
	assign en_bit = i2c_rsp.rdata[pmu_i2c_pkg::EN_BIT[cmd.rail]];

	always_comb begin
		i2c_req.rd = 1'b1;
		i2c_req.wdata = '0;
		if (cmd.kind == pmu_bus_pkg::PARAM_VOLTAGE)
			i2c_req.subaddr = pmu_i2c_pkg::VOLT_REG[cmd.rail];
		else
			i2c_req.subaddr = pmu_i2c_pkg::REG_ENABLE;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= Q_IDLE;
			reply_strobe <= 1'b0;
		end else begin
			reply_strobe <= own_done;
			if (state == Q_IDLE && query_strobe)
				state <= Q_READ;
			else if (own_done)
				state <= Q_IDLE;
		end
	end

	// On a failed read the raw byte goes back, all ones from the released bus
	always_ff @(posedge clk) begin
		if (state == Q_IDLE && query_strobe)
			cmd <= query_cmd;
		if (own_done) begin
			ok_q <= !i2c_rsp.failed;
			if (i2c_rsp.failed || cmd.kind == pmu_bus_pkg::PARAM_VOLTAGE)
				data_q <= i2c_rsp.rdata;
			else
				data_q <= {7'b0, en_bit};
		end
	end

	always_comb begin
		reply.eid = cmd.eid;
		reply.query = 1'b1;
		reply.ok = ok_q;
		reply.data = data_q;
	end

endmodule

/* design/i2c_arbiter.sv */
`timescale 1ns/100ps

module i2c_arbiter (
	input logic clk,
	input logic reset,
	input pmu_i2c_pkg::i2c_req_t set_req,
	input logic set_req_valid,
	input pmu_i2c_pkg::i2c_req_t query_req,
	input logic query_req_valid,
	input logic done,
	output logic set_grant,
	output logic query_grant,
	output pmu_i2c_pkg::i2c_req_t req,
	output logic start,
	output logic set_done,
	output logic query_done
);

	logic last_query;
	logic busy;

	assign busy = set_grant || query_grant;
	assign req = query_grant ? query_req : set_req;
	assign set_done = done && set_grant;
	assign query_done = done && query_grant;

	always_ff @(posedge clk) begin
		if (reset) begin
			set_grant <= 1'b0;
			query_grant <= 1'b0;
			last_query <= 1'b0;
			start <= 1'b0;
		end else begin
			start <= 1'b0;
			if (busy) begin
				if (done) begin
					set_grant <= 1'b0;
					query_grant <= 1'b0;
				end
			end else if (set_req_valid && (!query_req_valid || last_query)) begin
				set_grant <= 1'b1;
				last_query <= 1'b0;
				start <= 1'b1;
			end else if (query_req_valid) begin
				query_grant <= 1'b1;
				last_query <= 1'b1;
				start <= 1'b1;
			end
		end
	end

	one_owner: assert property (@(posedge clk) disable iff (reset)
		!(set_grant && query_grant))
		else $error("both engines own the I2C master");

endmodule

/* design/pmu_i2c_master.sv */
`timescale 1ns/100ps

module pmu_i2c_master #(
	parameter int CLK_DIV = 4
) (
	input logic clk,
	input logic reset,
	input pmu_i2c_pkg::i2c_req_t req,
	input logic start,
	output logic done,
	output pmu_i2c_pkg::i2c_rsp_t rsp,
	inout wire scl,
	inout wire sda
);

	localparam int QW = $clog2(CLK_DIV + 1);

	typedef enum logic [2:0] {M_IDLE, M_START, M_BIT, M_ACK, M_STOP} state_t;

	state_t state;
	pmu_i2c_pkg::i2c_req_t req_q;
	logic [QW-1:0] qcnt;
	logic [1:0] phase;
	logic [2:0] bit_cnt;
	logic [1:0] byte_idx;
	logic [1:0] nbytes;
	logic [7:0] cur_byte;
	logic [7:0] shreg;
	logic second;
	logic sda_smp;
	logic nak;
	logic tick;
	logic scl_lo;
	logic sda_lo;
	logic scl_lo_next;
	logic sda_lo_next;

	assign scl = scl_lo ? 1'b0 : 1'bz;
	assign sda = sda_lo ? 1'b0 : 1'bz;
	assign tick = (qcnt == QW'(CLK_DIV - 1));
	assign nbytes = (second || req_q.rd) ? 2'd2 : 2'd3;
	// The data byte of a read is acknowledged by us, so no check there
	assign nak = sda_smp && !(second && byte_idx == nbytes);

	always_comb begin
		case (byte_idx)
			2'd0: cur_byte = second ? pmu_i2c_pkg::DEV_ADDR_RD : pmu_i2c_pkg::DEV_ADDR_WR;
			2'd1: cur_byte = second ? 8'hFF : req_q.subaddr;
			default: cur_byte = req_q.wdata;
		endcase
	end

	// SDA only moves while SCL is low, except for the start and stop edges
	always_comb begin
		scl_lo_next = 1'b0;
		sda_lo_next = 1'b0;
		case (state)
			M_START: begin
				scl_lo_next = (phase == 2'd3);
				sda_lo_next = (phase != 2'd0);
			end
			M_BIT: begin
				scl_lo_next = (phase == 2'd0) || (phase == 2'd3);
				sda_lo_next = !shreg[7];
			end
			M_ACK: scl_lo_next = (phase == 2'd0) || (phase == 2'd3);
			M_STOP: begin
				scl_lo_next = (phase == 2'd0);
				sda_lo_next = (phase <= 2'd1);
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= M_IDLE;
			qcnt <= '0;
			phase <= '0;
			done <= 1'b0;
			scl_lo <= 1'b0;
			sda_lo <= 1'b0;
		end else begin
			done <= 1'b0;
			scl_lo <= scl_lo_next;
			sda_lo <= sda_lo_next;
			if (state == M_IDLE) begin
				qcnt <= '0;
				phase <= '0;
				if (start)
					state <= M_START;
			end else begin
				qcnt <= tick ? '0 : qcnt + 1'b1;
				if (tick)
					phase <= phase + 1'b1;
				if (tick && phase == 2'd3) begin
					case (state)
						M_START: state <= M_BIT;
						M_BIT: if (bit_cnt == 3'd0) state <= M_ACK;
						M_ACK: state <= (nak || byte_idx == nbytes) ? M_STOP : M_BIT;
						default: begin
							if (!rsp.failed && req_q.rd && !second) begin
								state <= M_START;
							end else begin
								state <= M_IDLE;
								done <= 1'b1;
							end
						end
					endcase
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == M_IDLE && start) begin
			req_q <= req;
			second <= 1'b0;
			byte_idx <= '0;
			rsp.failed <= 1'b0;
			rsp.rdata <= 8'hFF;
		end
		if (tick) begin
			case (state)
				M_START: begin
					if (phase == 2'd3) begin
						shreg <= cur_byte;
						bit_cnt <= 3'd7;
					end
				end
				M_BIT: begin
					if (phase == 2'd2)
						sda_smp <= sda;
					if (phase == 2'd3) begin
						shreg <= {shreg[6:0], sda_smp};
						bit_cnt <= bit_cnt - 1'b1;
						if (bit_cnt == 3'd0)
							byte_idx <= byte_idx + 1'b1;
					end
				end
				M_ACK: begin
					if (phase == 2'd2)
						sda_smp <= sda;
					if (phase == 2'd3) begin
						if (nak)
							rsp.failed <= 1'b1;
						if (second && byte_idx == nbytes)
							rsp.rdata <= shreg;
						shreg <= cur_byte;
						bit_cnt <= 3'd7;
					end
				end
				M_STOP: begin
					if (phase == 2'd3) begin
						second <= 1'b1;
						byte_idx <= '0;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

/* design/reply_builder.sv */
`timescale 1ns/100ps

module reply_builder (
	input logic clk,
	input logic reset,
	input pmu_bus_pkg::reply_t reply,
	input logic reply_strobe,
	output logic tx_frame,
	output logic tx_valid,
	output pmu_bus_pkg::bus_byte_t tx_byte
);

	pmu_bus_pkg::reply_t rep;
	logic sending;
	logic [2:0] idx;
	logic finished;

	// Query replies carry one data byte after the code
	assign finished = rep.query ? (idx == 3'd4) : (idx == 3'd3);

	always_ff @(posedge clk) begin
		if (reset) begin
			sending <= 1'b0;
			tx_frame <= 1'b0;
			tx_valid <= 1'b0;
			idx <= '0;
		end else begin
			tx_valid <= 1'b0;
			if (!sending) begin
				if (reply_strobe) begin
					sending <= 1'b1;
					tx_frame <= 1'b1;
					tx_valid <= 1'b1;
					idx <= 3'd1;
				end
			end else if (finished) begin
				sending <= 1'b0;
				tx_frame <= 1'b0;
			end else begin
				tx_valid <= 1'b1;
				idx <= idx + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!sending && reply_strobe) begin
			rep <= reply;
			tx_byte <= pmu_bus_pkg::REPLY_ADDR;
		end else if (sending && !finished) begin
			case (idx)
				3'd1: tx_byte <= rep.eid;
				3'd2: tx_byte <= rep.ok ? pmu_bus_pkg::ACK_CODE : pmu_bus_pkg::NAK_CODE;
				default: tx_byte <= rep.data;
			endcase
		end
	end

	no_overlap: assert property (@(posedge clk) disable iff (reset)
		reply_strobe |-> !sending)
		else $error("reply strobe arrived while a reply was still going out");

endmodule

/* design/pmu_ctrl_top.sv */
`timescale 1ns/100ps

module pmu_ctrl_top #(
	parameter pmu_bus_pkg::bus_byte_t SET_ADDR = 8'h70,
	parameter pmu_bus_pkg::bus_byte_t QUERY_ADDR = 8'h50,
	parameter int CLK_DIV = 4
) (
	input logic clk,
	input logic reset,
	input logic rx_frame,
	input logic rx_valid,
	input pmu_bus_pkg::bus_byte_t rx_byte,
	output logic tx_frame,
	output logic tx_valid,
	output pmu_bus_pkg::bus_byte_t tx_byte,
	inout wire scl,
	inout wire sda
);

	pmu_bus_pkg::set_cmd_t set_cmd;
	pmu_bus_pkg::query_cmd_t query_cmd;
	pmu_bus_pkg::reply_t set_reply;
	pmu_bus_pkg::reply_t query_reply;
	pmu_bus_pkg::reply_t reply;
	pmu_i2c_pkg::i2c_req_t set_req;
	pmu_i2c_pkg::i2c_req_t query_req;
	pmu_i2c_pkg::i2c_req_t i2c_req;
	pmu_i2c_pkg::i2c_rsp_t i2c_rsp;
	logic set_strobe;
	logic query_strobe;
	logic set_req_valid;
	logic query_req_valid;
	logic set_grant;
	logic query_grant;
	logic set_done;
	logic query_done;
	logic i2c_start;
	logic i2c_done;
	logic set_reply_strobe;
	logic query_reply_strobe;
	logic reply_strobe;

	// Both engines finish only on an I2C done, so their strobes never coincide
	assign reply_strobe = set_reply_strobe || query_reply_strobe;
	assign reply = set_reply_strobe ? set_reply : query_reply;

	frame_receiver #(
		.SET_ADDR(SET_ADDR),
		.QUERY_ADDR(QUERY_ADDR)
	) frame_receiver_i (
		.clk(clk),
		.reset(reset),
		.rx_frame(rx_frame),
		.rx_valid(rx_valid),
		.rx_byte(rx_byte),
		.set_cmd(set_cmd),
		.set_strobe(set_strobe),
		.query_cmd(query_cmd),
		.query_strobe(query_strobe)
	);

	rail_set_engine rail_set_engine_i (
		.clk(clk),
		.reset(reset),
		.set_cmd(set_cmd),
		.set_strobe(set_strobe),
		.grant(set_grant),
		.i2c_done(set_done),
		.i2c_rsp(i2c_rsp),
		.i2c_req(set_req),
		.i2c_req_valid(set_req_valid),
		.reply(set_reply),
		.reply_strobe(set_reply_strobe)
	);

	rail_query_engine rail_query_engine_i (
		.clk(clk),
		.reset(reset),
		.query_cmd(query_cmd),
		.query_strobe(query_strobe),
		.grant(query_grant),
		.i2c_done(query_done),
		.i2c_rsp(i2c_rsp),
		.i2c_req(query_req),
		.i2c_req_valid(query_req_valid),
		.reply(query_reply),
		.reply_strobe(query_reply_strobe)
	);

	i2c_arbiter i2c_arbiter_i (
		.clk(clk),
		.reset(reset),
		.set_req(set_req),
		.set_req_valid(set_req_valid),
		.query_req(query_req),
		.query_req_valid(query_req_valid),
		.done(i2c_done),
		.set_grant(set_grant),
		.query_grant(query_grant),
		.req(i2c_req),
		.start(i2c_start),
		.set_done(set_done),
		.query_done(query_done)
	);

	pmu_i2c_master #(
		.CLK_DIV(CLK_DIV)
	) pmu_i2c_master_i (
		.clk(clk),
		.reset(reset),
		.req(i2c_req),
		.start(i2c_start),
		.done(i2c_done),
		.rsp(i2c_rsp),
		.scl(scl),
		.sda(sda)
	);

	reply_builder reply_builder_i (
		.clk(clk),
		.reset(reset),
		.reply(reply),
		.reply_strobe(reply_strobe),
		.tx_frame(tx_frame),
		.tx_valid(tx_valid),
		.tx_byte(tx_byte)
	);

endmodule

/* testbench/pmu_i2c_model.sv */
`timescale 1ns/100ps

module pmu_i2c_model #(
	parameter logic [6:0] DEV_ADDR = 7'h34
) (
	input logic no_ack,
	inout wire scl,
	inout wire sda
);

	logic [7:0] regs [0:255];
	logic [7:0] last_wr_addr;
	logic [7:0] shift;
	logic [7:0] rd_data;
	logic [7:0] ptr;
	int bit_cnt;
	int byte_cnt;
	logic active;
	logic reading;
	logic sda_lo;

	assign sda = sda_lo ? 1'b0 : 1'bz;

	// Unwritten registers hold a pattern of their own address
	initial begin
		for (int i = 0; i < 256; i++)
			regs[i] = 8'(i) ^ 8'hA5;
		active = 1'b0;
		reading = 1'b0;
		sda_lo = 1'b0;
		ptr = 8'h00;
		bit_cnt = 0;
		byte_cnt = 0;
	end

	// Start and stop are the only SDA edges while SCL is high
	always @(negedge sda) begin
		if (scl === 1'b1) begin
			active = 1'b1;
			reading = 1'b0;
			bit_cnt = 0;
			byte_cnt = 0;
		end
	end

	always @(posedge sda) begin
		if (scl === 1'b1)
			active = 1'b0;
	end

	always @(posedge scl) begin
		if (active) begin
			if (bit_cnt < 8) begin
				shift = {shift[6:0], (sda === 1'b0) ? 1'b0 : 1'b1};
				bit_cnt = bit_cnt + 1;
			end else begin
				bit_cnt = 0;
				// The master ends a read by leaving its acknowledge bit high
				if (reading && sda !== 1'b0)
					active = 1'b0;
			end
		end
	end

	always @(negedge scl) begin
		if (active) begin
			sda_lo = 1'b0;
			if (bit_cnt == 8 && !reading) begin
				if (no_ack) begin
					active = 1'b0;
				end else if (byte_cnt == 0) begin
					if (shift[7:1] == DEV_ADDR) begin
						sda_lo = 1'b1;
						reading = shift[0];
						rd_data = regs[ptr];
					end else begin
						active = 1'b0;
					end
				end else if (byte_cnt == 1) begin
					ptr = shift;
					sda_lo = 1'b1;
				end else begin
					regs[ptr] = shift;
					last_wr_addr = ptr;
					ptr = ptr + 1'b1;
					sda_lo = 1'b1;
				end
				byte_cnt = byte_cnt + 1;
			end else if (reading && bit_cnt < 8) begin
				sda_lo = !rd_data[7 - bit_cnt];
			end
		end
	end

endmodule

/* testbench/pmu_ctrl_tb.sv */
`timescale 1ns/100ps

module pmu_ctrl_tb;

	localparam int CLK_PERIOD = 100;
	localparam int CLK_DIV = 4;
	// Longest transaction is a read: two starts, two stops and four 9-bit bytes
	localparam int XACT_CYCLES = 40 * 4 * CLK_DIV;
	localparam int REPLY_LIMIT = 2 * XACT_CYCLES + 50;

	typedef struct packed {
		logic [2:0] nbytes;
		logic [39:0] frame;
		logic no_ack;
		logic [2:0] nreply;
		logic [31:0] reply;
		logic chk_reg;
		logic [7:0] reg_addr;
		logic [7:0] reg_val;
	} row_t;

	logic clk = 1'b0;
	logic reset;
	logic rx_frame;
	logic rx_valid;
	pmu_bus_pkg::bus_byte_t rx_byte;
	logic tx_frame;
	logic tx_valid;
	pmu_bus_pkg::bus_byte_t tx_byte;
	logic no_ack;
	wire scl;
	wire sda;

	row_t rows[$];
	string names[$];
	logic table_ready = 1'b0;
	int errors = 0;
	int checks = 0;

	pullup (scl);
	pullup (sda);

	always #(CLK_PERIOD / 2) clk = ~clk;

	pmu_ctrl_top #(
		.SET_ADDR(8'h70),
		.QUERY_ADDR(8'h50),
		.CLK_DIV(CLK_DIV)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.rx_frame(rx_frame),
		.rx_valid(rx_valid),
		.rx_byte(rx_byte),
		.tx_frame(tx_frame),
		.tx_valid(tx_valid),
		.tx_byte(tx_byte),
		.scl(scl),
		.sda(sda)
	);

	pmu_i2c_model pmic_i (
		.no_ack(no_ack),
		.scl(scl),
		.sda(sda)
	);

	task automatic add_row(input string name, input int nbytes, input logic [39:0] frame,
			input logic nak, input int nreply, input logic [31:0] reply,
			input logic chk, input logic [7:0] addr, input logic [7:0] val);
		row_t r;
		r.nbytes = nbytes[2:0];
		r.frame = frame;
		r.no_ack = nak;
		r.nreply = nreply[2:0];
		r.reply = reply;
		r.chk_reg = chk;
		r.reg_addr = addr;
		r.reg_val = val;
		rows.push_back(r);
		names.push_back(name);
	endtask

	// Frame bytes and reply bytes read left to right, first byte leftmost
	task automatic build_table();
		add_row("en_set_r0", 5, 40'h70_11_65_00_01, 0, 3, 32'h20_11_01_00, 1, 8'h10, 8'h10);
		add_row("en_set_r1", 5, 40'h70_12_65_01_01, 0, 3, 32'h20_12_01_00, 1, 8'h10, 8'h12);
		add_row("en_set_r2", 5, 40'h70_13_65_02_01, 0, 3, 32'h20_13_01_00, 1, 8'h10, 8'h16);
		add_row("en_set_r3", 5, 40'h70_14_65_03_01, 0, 3, 32'h20_14_01_00, 1, 8'h10, 8'h17);
		add_row("en_clr_r1", 5, 40'h70_15_65_01_00, 0, 3, 32'h20_15_01_00, 1, 8'h10, 8'h15);
		add_row("volt_set_r0", 5, 40'h70_21_76_00_ea, 0, 3, 32'h20_21_01_00, 1, 8'h32, 8'h0a);
		add_row("volt_set_r1", 5, 40'h70_22_76_01_13, 0, 3, 32'h20_22_01_00, 1, 8'h26, 8'h13);
		add_row("volt_set_r2", 5, 40'h70_23_76_02_3f, 0, 3, 32'h20_23_01_00, 1, 8'h29, 8'h1f);
		add_row("volt_set_r3", 5, 40'h70_24_76_03_c5, 0, 3, 32'h20_24_01_00, 1, 8'h23, 8'h05);
		add_row("volt_query_r0", 4, 40'h50_31_76_00_00, 0, 4, 32'h20_31_01_0a, 0, 8'h00, 8'h00);
		add_row("volt_query_r3", 4, 40'h50_32_76_03_00, 0, 4, 32'h20_32_01_05, 0, 8'h00, 8'h00);
		add_row("en_query_r0", 4, 40'h50_33_65_00_00, 0, 4, 32'h20_33_01_01, 0, 8'h00, 8'h00);
		add_row("en_query_r1", 4, 40'h50_34_65_01_00, 0, 4, 32'h20_34_01_00, 0, 8'h00, 8'h00);
		add_row("en_query_r3", 4, 40'h50_35_65_03_00, 0, 4, 32'h20_35_01_01, 0, 8'h00, 8'h00);
		add_row("nak_set", 5, 40'h70_41_76_02_10, 1, 3, 32'h20_41_00_00, 0, 8'h00, 8'h00);
		add_row("nak_query", 4, 40'h50_42_76_01_00, 1, 4, 32'h20_42_00_ff, 0, 8'h00, 8'h00);
		add_row("wrong_addr", 5, 40'h30_51_65_00_01, 0, 0, 32'h00_00_00_00, 0, 8'h00, 8'h00);
		add_row("short_set", 4, 40'h70_52_65_00_00, 0, 0, 32'h00_00_00_00, 0, 8'h00, 8'h00);
		add_row("short_query", 3, 40'h50_53_76_00_00, 0, 0, 32'h00_00_00_00, 0, 8'h00, 8'h00);
		add_row("after_drop", 5, 40'h70_54_65_02_00, 0, 3, 32'h20_54_01_00, 1, 8'h10, 8'h11);
		add_row("en_query_r2", 4, 40'h50_55_65_02_00, 0, 4, 32'h20_55_01_00, 0, 8'h00, 8'h00);
	endtask

	task automatic compare_byte(input string test, input string what,
			input logic [7:0] expected, input logic [7:0] actual);
		checks++;
		if (actual !== expected) begin
			$display("MISMATCH %s %s: expected %02h, actual %02h", test, what, expected, actual);
			errors++;
		end
	endtask

	task automatic send_frame(input row_t r);
		rx_frame = 1'b1;
		for (int i = 0; i < r.nbytes; i++) begin
			rx_valid = 1'b1;
			rx_byte = r.frame[39 - 8 * i -: 8];
			@(negedge clk);
			rx_valid = 1'b0;
			repeat ($urandom_range(2, 0)) @(negedge clk);
		end
		rx_frame = 1'b0;
	endtask

	task automatic wait_reply(input int limit, output logic seen);
		int n;
		n = 0;
		while (!tx_frame && n < limit) begin
			@(negedge clk);
			n++;
		end
		seen = tx_frame;
	endtask

	task automatic run_row(input int idx);
		row_t r;
		logic seen;
		pmu_bus_pkg::bus_byte_t got[$];
		r = rows[idx];
		no_ack = r.no_ack;
		repeat ($urandom_range(4, 1)) @(negedge clk);
		send_frame(r);
		wait_reply(REPLY_LIMIT, seen);
		checks++;
		if (r.nreply == 0) begin
			if (seen) begin
				$display("%s: a reply went out for a frame that should be ignored", names[idx]);
				errors++;
			end
			while (tx_frame)
				@(negedge clk);
			return;
		end
		if (!seen) begin
			$display("%s: no reply within %0d clock cycles", names[idx], REPLY_LIMIT);
			errors++;
			return;
		end
		while (tx_frame) begin
			if (tx_valid)
				got.push_back(tx_byte);
			@(negedge clk);
		end
		compare_byte(names[idx], "reply length", 8'(r.nreply), 8'(got.size()));
		for (int i = 0; i < r.nreply && i < got.size(); i++)
			compare_byte(names[idx], $sformatf("reply byte %0d", i),
				r.reply[31 - 8 * i -: 8], got[i]);
		if (r.chk_reg)
			compare_byte(names[idx], $sformatf("register %02h", r.reg_addr),
				r.reg_val, pmic_i.regs[r.reg_addr]);
		// Every acknowledged set ends with the slew write
		if (r.nreply == 3 && r.reply[15:8] == pmu_bus_pkg::ACK_CODE) begin
			compare_byte(names[idx], "slew register", pmu_i2c_pkg::SLEW_VALUE,
				pmic_i.regs[pmu_i2c_pkg::REG_SLEW]);
			compare_byte(names[idx], "last write address", pmu_i2c_pkg::REG_SLEW,
				pmic_i.last_wr_addr);
		end
	endtask

	initial begin
		void'($urandom(90658));
		reset = 1'b1;
		rx_frame = 1'b0;
		rx_valid = 1'b0;
		rx_byte = 8'h00;
		no_ack = 1'b0;
		build_table();
		table_ready = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < rows.size(); i++)
			run_row(i);
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	initial begin
		wait (table_ready);
		#(rows.size() * (2 * XACT_CYCLES + 200) * CLK_PERIOD);
		$display("Timeout: the tests did not finish in the expected time");
		errors++;
		$display("Summary: %0d checks, %0d errors", checks, errors);
		$display("Errors found");
		$finish;
	end

endmodule

/* all.f */
design/pmu_bus_pkg.sv
design/pmu_i2c_pkg.sv
design/frame_receiver.sv
design/rail_set_engine.sv
design/rail_query_engine.sv
design/i2c_arbiter.sv
design/pmu_i2c_master.sv
design/reply_builder.sv
design/pmu_ctrl_top.sv
testbench/pmu_i2c_model.sv
testbench/pmu_ctrl_tb.sv

/* Bender.yml */
package:
  name: pmu_ctrl

sources:
  - design/pmu_bus_pkg.sv
  - design/pmu_i2c_pkg.sv
  - design/frame_receiver.sv
  - design/rail_set_engine.sv
  - design/rail_query_engine.sv
  - design/i2c_arbiter.sv
  - design/pmu_i2c_master.sv
  - design/reply_builder.sv
  - design/pmu_ctrl_top.sv
  - target: test
    files:
      - testbench/pmu_i2c_model.sv
      - testbench/pmu_ctrl_tb.sv
